// ==== source/memctl_pkg.sv ====
// memory map decodes address bit 26 then bit 25; ROM and CSR views assume word aligned access
package memctl_pkg;

  // size codes are log2 of the byte count, codes above 32-bit mean ROM bursts
  localparam logic [2:0] CMD_SIZE_8  = 3'd0;
  localparam logic [2:0] CMD_SIZE_16 = 3'd1;
  localparam logic [2:0] CMD_SIZE_32 = 3'd2;
  // 8-word burst
  localparam logic [2:0] MAX_SIZE_CODE = 3'd5;

  localparam int SDRAM_ADDR_BITS = 24;
  localparam int ROM_ADDR_BITS   = 12;
  // 16 registers of 32 bits
  localparam int CSR_ADDR_BITS   = 6;

  localparam int SEL_SDRAM_BIT = 26;
  localparam int SEL_CSR_BIT   = 25;

  typedef struct packed {
    logic        valid;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [2:0]  size;
  } dbus_cmd_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [2:0]  size;
  } ibus_cmd_t;

  typedef struct packed {
    logic                       rd;
    logic                       wr;
    logic                       ack;
    logic [SDRAM_ADDR_BITS-1:0] addr;
    logic [15:0]                wdata;
    logic [1:0]                 wmask;
  } sdram_req_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [CSR_ADDR_BITS-3:0] adr;
    logic [31:0]              dat;
  } csr_req_t;

  // one CPU address, seen as SDRAM halfword address or as ROM/CSR word address
  typedef union packed {
    struct packed {
      logic [31-SDRAM_ADDR_BITS-1:0] region;
      logic [SDRAM_ADDR_BITS-1:0]    half_idx;
      logic                          byte_sel;
    } sdram;
    struct packed {
      logic [31-ROM_ADDR_BITS:0] region;
      logic [ROM_ADDR_BITS-3:0]  word_idx;
      logic [1:0]                lane;
    } io;
  } mem_addr_u;

  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_ROM,
    SRC_CSR,
    SRC_SDRAM
  } src_e;

endpackage

// ==== source/rsp_path.sv ====
// one registered word shared by both CPU buses; valid only with a response strobe
`timescale 1ns/1ps

module rsp_path import memctl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        capture_i,
  input  src_e        src_i,
  input  logic [31:0] rom_data_i,
  input  logic [31:0] csr_data_i,
  input  logic [31:0] sdram_data_i,
  output logic [31:0] rsp_data_o
);

  logic [31:0] data_q;

  assign rsp_data_o = data_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_q <= '0;
    end else if (capture_i) begin
      case (src_i)
        SRC_ROM:   data_q <= rom_data_i;
        SRC_CSR:   data_q <= csr_data_i;
        SRC_SDRAM: data_q <= sdram_data_i;
        default:   data_q <= '0;
      endcase
    end
  end

endmodule

// ==== source/rom_reader.sv ====
// ROM needs exactly one cycle of read delay; sizes below a word read one word
`timescale 1ns/1ps

module rom_reader import memctl_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     start_i,
  input  dbus_cmd_t                cmd_i,
  output logic [ROM_ADDR_BITS-3:0] rom_addr_o,
  output logic                     word_o,
  output logic                     last_o
);

  mem_addr_u                addr_u;
  logic [ROM_ADDR_BITS-3:0] addr_q;
  logic [MAX_SIZE_CODE-3:0] remain_q;
  logic [MAX_SIZE_CODE-3:0] remain_nx;
  logic [MAX_SIZE_CODE-3:0] count_init;
  logic                     word_q;
  logic                     last_q;

  assign addr_u    = cmd_i.addr;
  assign remain_nx = remain_q - 1'b1;
  assign word_o    = word_q;
  assign last_o    = last_q;

  // start address goes out right away so the first word is not delayed
  assign rom_addr_o = start_i ? addr_u.io.word_idx : addr_q;

  // words after the first, 2^(size-2)-1
  always_comb begin
    if (cmd_i.size > CMD_SIZE_32) begin
      count_init = ~({(MAX_SIZE_CODE-2){1'b1}} << (cmd_i.size - CMD_SIZE_32));
    end else begin
      count_init = '0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      remain_q <= '0;
      word_q   <= 1'b0;
      last_q   <= 1'b0;
    end else if (start_i) begin
      remain_q <= count_init;
      word_q   <= 1'b1;
      last_q   <= (count_init == '0);
    end else if (remain_q != '0) begin
      remain_q <= remain_nx;
      word_q   <= 1'b1;
      last_q   <= (remain_nx == '0);
    end else begin
      word_q <= 1'b0;
      last_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= rom_addr_o + 1'b1;
  end

endmodule

// ==== source/csr_port.sv ====
// single 32-bit access per command; read data is valid only in the ack cycle
`timescale 1ns/1ps

module csr_port import memctl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  dbus_cmd_t   cmd_i,
  output csr_req_t    csr_o,
  input  logic        csr_stall_i,
  input  logic        csr_ack_i,
  input  logic [31:0] csr_dat_i,
  output logic        done_o,
  output logic        rd_o,
  output logic [31:0] rdata_o
);

  mem_addr_u                addr_u;
  logic                     cyc_q;
  logic                     stb_q;
  logic                     we_q;
  logic [CSR_ADDR_BITS-3:0] adr_q;
  logic [31:0]              dat_q;

  assign addr_u  = cmd_i.addr;
  assign csr_o   = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};
  assign done_o  = cyc_q && csr_ack_i;
  assign rd_o    = !we_q;
  assign rdata_o = csr_dat_i;

  // pipelined bus, stb lasts until the slave takes the request
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
    end else if (start_i) begin
      cyc_q <= 1'b1;
      stb_q <= 1'b1;
    end else begin
      if (stb_q && !csr_stall_i) stb_q <= 1'b0;
      if (done_o) cyc_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_q <= addr_u.io.word_idx[CSR_ADDR_BITS-3:0];
      we_q  <= cmd_i.wr;
      dat_q <= cmd_i.data;
    end
  end

endmodule

// ==== source/sdram_port.sv ====
// 32-bit transfers go as two halfwords low first; SDRAM reads are always one full word
`timescale 1ns/1ps

module sdram_port import memctl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  dbus_cmd_t   cmd_i,
  output sdram_req_t  sdram_o,
  input  logic        sdram_rdy_i,
  input  logic [15:0] sdram_rdata_i,
  output logic        done_o,
  output logic        word_o,
  output logic [31:0] rdata_o
);

  mem_addr_u                  addr_u;
  logic                       rd_q;
  logic                       wr_q;
  logic                       ack_q;
  logic                       busy_q;
  logic                       hi_pend_q;
  logic                       is_wr_q;
  logic [1:0]                 wait_q;
  logic [SDRAM_ADDR_BITS-1:0] addr_q;
  logic [15:0]                wdata_q;
  logic [15:0]                data_hi_q;
  logic [15:0]                low_q;
  logic [1:0]                 wmask_q;
  logic [1:0]                 mask_hi_q;
  logic                       two_half;
  logic                       half_done;

  assign addr_u   = cmd_i.addr;
  assign two_half = !cmd_i.wr || (cmd_i.size > CMD_SIZE_16);

  // rdy only counts from the third cycle of a request
  assign half_done = busy_q && !ack_q && (wait_q == 2'd2) && sdram_rdy_i;
  assign done_o    = half_done && !hi_pend_q;
  assign word_o    = done_o && !is_wr_q;
  assign rdata_o   = {sdram_rdata_i, low_q};

  assign sdram_o = '{rd: rd_q, wr: wr_q, ack: ack_q, addr: addr_q, wdata: wdata_q,
                     wmask: wmask_q};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      ack_q     <= 1'b0;
      busy_q    <= 1'b0;
      hi_pend_q <= 1'b0;
      wait_q    <= 2'd0;
    end else begin
      ack_q <= 1'b0;
      if (start_i) begin
        rd_q      <= !cmd_i.wr;
        wr_q      <= cmd_i.wr;
        busy_q    <= 1'b1;
        hi_pend_q <= two_half;
        wait_q    <= 2'd0;
      end else if (busy_q) begin
        if (ack_q) begin
          // low half acknowledged, raise the request again for the high half
          rd_q      <= !is_wr_q;
          wr_q      <= is_wr_q;
          hi_pend_q <= 1'b0;
          wait_q    <= 2'd0;
        end else if (wait_q != 2'd2) begin
          wait_q <= wait_q + 1'b1;
        end else if (sdram_rdy_i) begin
          rd_q   <= 1'b0;
          wr_q   <= 1'b0;
          ack_q  <= 1'b1;
          busy_q <= hi_pend_q;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      is_wr_q   <= cmd_i.wr;
      addr_q    <= two_half ? {addr_u.sdram.half_idx[SDRAM_ADDR_BITS-1:1], 1'b0}
                            : addr_u.sdram.half_idx;
      wdata_q   <= cmd_i.data[15:0];
      data_hi_q <= cmd_i.data[31:16];
      // byte and halfword writes fold both mask pairs onto one halfword
      if (!cmd_i.wr) begin
        wmask_q <= 2'b11;
      end else if (two_half) begin
        wmask_q <= cmd_i.mask[1:0];
      end else begin
        wmask_q <= cmd_i.mask[1:0] | cmd_i.mask[3:2];
      end
      mask_hi_q <= cmd_i.wr ? cmd_i.mask[3:2] : 2'b11;
    end else if (busy_q && ack_q) begin
      addr_q[0] <= 1'b1;
      wdata_q   <= data_hi_q;
      wmask_q   <= mask_hi_q;
    end
    if (half_done && hi_pend_q) low_q <= sdram_rdata_i;
  end

  // byte data goes out unchanged, so the CPU has to repeat it across the halfword
  a_byte_repeat: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i && cmd_i.wr && cmd_i.size == CMD_SIZE_8 |=> wdata_q[15:8] == wdata_q[7:0]);

endmodule

// ==== source/dispatch_fsm.sv ====
// instruction bus always targets boot ROM; writes to ROM and other bad commands are just retired
`timescale 1ns/1ps

module dispatch_fsm import memctl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  dbus_cmd_t dbus_cmd_i,
  input  ibus_cmd_t ibus_cmd_i,
  input  logic      sdram_done_i,
  input  logic      sdram_word_i,
  input  logic      csr_done_i,
  input  logic      csr_rd_i,
  input  logic      rom_word_i,
  input  logic      rom_last_i,
  output logic      dbus_ready_o,
  output logic      ibus_ready_o,
  output logic      dbus_rsp_valid_o,
  output logic      ibus_rsp_valid_o,
  output dbus_cmd_t cmd_o,
  output logic      sdram_start_o,
  output logic      csr_start_o,
  output logic      rom_start_o,
  output src_e      src_o,
  output logic      capture_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SDRAM,
    ST_CSR,
    ST_ROM,
    ST_FINISH
  } state_e;

  state_e    state_q;
  dbus_cmd_t cmd_q;
  logic      from_ibus_q;
  mem_addr_u dbus_addr;
  logic      is_sdram;
  logic      is_csr;
  logic      dbus_take;
  logic      ibus_take;
  logic      rsp_fire;

  // region decode, SDRAM bit wins over CSR bit
  assign dbus_addr = dbus_cmd_i.addr;
  assign is_sdram  = dbus_addr.sdram.region[SEL_SDRAM_BIT - SDRAM_ADDR_BITS - 1];
  assign is_csr    = !is_sdram && dbus_addr.io.region[SEL_CSR_BIT - ROM_ADDR_BITS];

  // ready has to fall in the accept cycle itself
  assign dbus_ready_o = (state_q == ST_IDLE);
  assign ibus_ready_o = dbus_ready_o && !dbus_cmd_i.valid;
  assign dbus_take    = dbus_ready_o && dbus_cmd_i.valid;
  assign ibus_take    = ibus_ready_o && ibus_cmd_i.valid;

  assign cmd_o     = cmd_q;
  assign capture_o = rsp_fire;

  // the engine that owns the current state supplies the response word
  always_comb begin
    case (state_q)
      ST_ROM: begin
        src_o    = SRC_ROM;
        rsp_fire = rom_word_i;
      end
      ST_CSR: begin
        src_o    = SRC_CSR;
        rsp_fire = csr_done_i && csr_rd_i;
      end
      ST_SDRAM: begin
        src_o    = SRC_SDRAM;
        rsp_fire = sdram_word_i;
      end
      default: begin
        src_o    = SRC_NONE;
        rsp_fire = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q          <= ST_IDLE;
      from_ibus_q      <= 1'b0;
      sdram_start_o    <= 1'b0;
      csr_start_o      <= 1'b0;
      rom_start_o      <= 1'b0;
      dbus_rsp_valid_o <= 1'b0;
      ibus_rsp_valid_o <= 1'b0;
    end else begin
      sdram_start_o    <= 1'b0;
      csr_start_o      <= 1'b0;
      rom_start_o      <= 1'b0;
      dbus_rsp_valid_o <= rsp_fire && !from_ibus_q;
      ibus_rsp_valid_o <= rsp_fire && from_ibus_q;
      case (state_q)
        ST_IDLE: begin
          if (dbus_take) begin
            from_ibus_q <= 1'b0;
            if (is_sdram) begin
              state_q       <= ST_SDRAM;
              sdram_start_o <= 1'b1;
            end else if (is_csr) begin
              state_q     <= ST_CSR;
              csr_start_o <= 1'b1;
            end else if (!dbus_cmd_i.wr) begin
              state_q     <= ST_ROM;
              rom_start_o <= 1'b1;
            end else begin
              // write into ROM space
              state_q <= ST_FINISH;
            end
          end else if (ibus_take) begin
            from_ibus_q <= 1'b1;
            state_q     <= ST_ROM;
            rom_start_o <= 1'b1;
          end
        end
        ST_SDRAM: begin
          if (sdram_done_i) state_q <= ST_FINISH;
        end
        ST_CSR: begin
          if (csr_done_i) state_q <= ST_FINISH;
        end
        ST_ROM: begin
          if (rom_last_i) state_q <= ST_FINISH;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // latched command, instruction fetches are turned into data-bus reads
  always_ff @(posedge clk_i) begin
    if (dbus_take) begin
      cmd_q <= dbus_cmd_i;
    end else if (ibus_take) begin
      cmd_q <= '{valid: 1'b1, wr: 1'b0, addr: ibus_cmd_i.addr, data: '0, mask: '0,
                 size: ibus_cmd_i.size};
    end
  end

  // CSR registers are only reachable as whole words
  a_csr_word_size: assert property (@(posedge clk_i) disable iff (rst_i)
    dbus_take && is_csr |=> cmd_o.size == CMD_SIZE_32);

endmodule

// ==== source/mem_ctrl.sv ====
// one command in flight at a time; data bus wins over instruction bus, rsp_data_o is shared
`timescale 1ns/1ps

module mem_ctrl import memctl_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  dbus_cmd_t                dbus_cmd_i,
  output logic                     dbus_ready_o,
  output logic                     dbus_rsp_valid_o,
  input  ibus_cmd_t                ibus_cmd_i,
  output logic                     ibus_ready_o,
  output logic                     ibus_rsp_valid_o,
  output logic [31:0]              rsp_data_o,
  output sdram_req_t               sdram_o,
  input  logic                     sdram_rdy_i,
  input  logic [15:0]              sdram_rdata_i,
  output csr_req_t                 csr_o,
  input  logic                     csr_stall_i,
  input  logic                     csr_ack_i,
  input  logic [31:0]              csr_dat_i,
  output logic [ROM_ADDR_BITS-3:0] rom_addr_o,
  input  logic [31:0]              rom_data_i
);

  dbus_cmd_t   cmd;
  logic        sdram_start;
  logic        csr_start;
  logic        rom_start;
  logic        sdram_done;
  logic        sdram_word;
  logic [31:0] sdram_rdata;
  logic        csr_done;
  logic        csr_rd;
  logic [31:0] csr_rdata;
  logic        rom_word;
  logic        rom_last;
  src_e        src;
  logic        capture;

  dispatch_fsm dispatch_fsm_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dbus_cmd_i       (dbus_cmd_i),
    .ibus_cmd_i       (ibus_cmd_i),
    .sdram_done_i     (sdram_done),
    .sdram_word_i     (sdram_word),
    .csr_done_i       (csr_done),
    .csr_rd_i         (csr_rd),
    .rom_word_i       (rom_word),
    .rom_last_i       (rom_last),
    .dbus_ready_o     (dbus_ready_o),
    .ibus_ready_o     (ibus_ready_o),
    .dbus_rsp_valid_o (dbus_rsp_valid_o),
    .ibus_rsp_valid_o (ibus_rsp_valid_o),
    .cmd_o            (cmd),
    .sdram_start_o    (sdram_start),
    .csr_start_o      (csr_start),
    .rom_start_o      (rom_start),
    .src_o            (src),
    .capture_o        (capture)
  );

  sdram_port sdram_port_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (sdram_start),
    .cmd_i         (cmd),
    .sdram_o       (sdram_o),
    .sdram_rdy_i   (sdram_rdy_i),
    .sdram_rdata_i (sdram_rdata_i),
    .done_o        (sdram_done),
    .word_o        (sdram_word),
    .rdata_o       (sdram_rdata)
  );

  csr_port csr_port_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (csr_start),
    .cmd_i       (cmd),
    .csr_o       (csr_o),
    .csr_stall_i (csr_stall_i),
    .csr_ack_i   (csr_ack_i),
    .csr_dat_i   (csr_dat_i),
    .done_o      (csr_done),
    .rd_o        (csr_rd),
    .rdata_o     (csr_rdata)
  );

  rom_reader rom_reader_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (rom_start),
    .cmd_i      (cmd),
    .rom_addr_o (rom_addr_o),
    .word_o     (rom_word),
    .last_o     (rom_last)
  );

  rsp_path rsp_path_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .capture_i    (capture),
    .src_i        (src),
    .rom_data_i   (rom_data_i),
    .csr_data_i   (csr_rdata),
    .sdram_data_i (sdram_rdata),
    .rsp_data_o   (rsp_data_o)
  );

endmodule

// ==== verification/mem_checker.sv ====
// response words must come back in the order they were expected; sampled on the falling edge
`timescale 1ns/1ps

module mem_checker import memctl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        dbus_ready_i,
  input  logic        ibus_ready_i,
  input  logic        dbus_rsp_valid_i,
  input  logic        ibus_rsp_valid_i,
  input  logic [31:0] rsp_data_i,
  input  sdram_req_t  sdram_i,
  input  csr_req_t    csr_i
);

  typedef struct packed {
    logic        consec;
    logic        ibus;
    logic [31:0] word;
  } exp_item_t;

  exp_item_t expect_q [$];
  exp_item_t head;
  int        error_count = 0;
  int        check_count = 0;
  int        cycle_n = 0;
  int        last_rsp_n = -2;
  logic      sdram_req_prev = 1'b0;
  logic      ack_want;

  // consec marks a burst word that has to follow the previous one directly
  task automatic expect_word(input logic consec, input logic ibus, input logic [31:0] word);
    expect_q.push_back(exp_item_t'{consec: consec, ibus: ibus, word: word});
  endtask

  function automatic int pending();
    return expect_q.size();
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_reset_state();
    compare("dbus_ready_o", 32'(dbus_ready_i), 32'h1);
    compare("ibus_ready_o", 32'(ibus_ready_i), 32'h1);
    compare("dbus_rsp_valid_o", 32'(dbus_rsp_valid_i), 32'h0);
    compare("ibus_rsp_valid_o", 32'(ibus_rsp_valid_i), 32'h0);
    compare("sdram_o.rd", 32'(sdram_i.rd), 32'h0);
    compare("sdram_o.wr", 32'(sdram_i.wr), 32'h0);
    compare("sdram_o.ack", 32'(sdram_i.ack), 32'h0);
    compare("csr_o.cyc", 32'(csr_i.cyc), 32'h0);
    compare("csr_o.stb", 32'(csr_i.stb), 32'h0);
  endtask

  always @(negedge clk_i) begin
    cycle_n++;
    // ack is the single cycle right after rd or wr drops
    ack_want = sdram_req_prev && !sdram_i.rd && !sdram_i.wr;
    sdram_req_prev = sdram_i.rd || sdram_i.wr;
    if (!rst_i) begin
      compare("sdram_o.ack", 32'(sdram_i.ack), 32'(ack_want));
    end
    if (!rst_i && (dbus_rsp_valid_i || ibus_rsp_valid_i)) begin
      if (dbus_rsp_valid_i && ibus_rsp_valid_i) begin
        error_count++;
        $display("both response strobes were high in one cycle at %0t", $time);
      end else if (expect_q.size() == 0) begin
        error_count++;
        $display("a response pulse came while no word was expected at %0t", $time);
      end else begin
        head = expect_q.pop_front();
        compare("ibus_rsp_valid_o", 32'(ibus_rsp_valid_i), 32'(head.ibus));
        compare("rsp_data_o", rsp_data_i, head.word);
        if (head.consec && cycle_n != last_rsp_n + 1) begin
          error_count++;
          $display("burst word arrived %0d cycles late at %0t", cycle_n - last_rsp_n - 1,
                   $time);
        end
      end
      last_rsp_n = cycle_n;
    end
  end

endmodule

// ==== verification/tb_mem_ctrl.sv ====
// table-driven run with ROM, CSR and SDRAM models; needs timing support, SDRAM model holds 256 halfwords
`timescale 1ns/1ps

module tb_mem_ctrl import memctl_pkg::*; ();

  localparam logic [1:0] BUS_D  = 2'd0;
  localparam logic [1:0] BUS_I  = 2'd1;
  localparam logic [1:0] BUS_DI = 2'd2;
  localparam int NUM_ROWS       = 14;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 60 + 200;

  typedef struct packed {
    logic [1:0]  bus;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [2:0]  size;
    logic [31:0] exp;
  } row_t;

  logic                     clk_i;
  logic                     rst_i;
  dbus_cmd_t                dbus_cmd_i;
  logic                     dbus_ready_o;
  logic                     dbus_rsp_valid_o;
  ibus_cmd_t                ibus_cmd_i;
  logic                     ibus_ready_o;
  logic                     ibus_rsp_valid_o;
  logic [31:0]              rsp_data_o;
  sdram_req_t               sdram_o;
  logic                     sdram_rdy_i;
  logic [15:0]              sdram_rdata_i;
  csr_req_t                 csr_o;
  logic                     csr_stall_i;
  logic                     csr_ack_i;
  logic [31:0]              csr_dat_i;
  logic [ROM_ADDR_BITS-3:0] rom_addr_o;
  logic [31:0]              rom_data_i;

  row_t                     rows [NUM_ROWS];
  logic [15:0]              sdram_mem [256];
  logic [31:0]              csr_regs [16];
  logic [ROM_ADDR_BITS-3:0] rom_addr_prev;
  int                       sdram_age;
  int                       sdram_delay;
  int                       csr_stall_left;
  logic                     csr_stb_seen;
  logic                     csr_taken;
  logic                     csr_we_hold;
  logic [3:0]               csr_adr_hold;
  logic [31:0]              csr_dat_hold;
  logic [31:0]              seed_val;
  int                       cycle_count;

  mem_ctrl mem_ctrl_inst (.*);

  mem_checker mem_checker_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dbus_ready_i     (dbus_ready_o),
    .ibus_ready_i     (ibus_ready_o),
    .dbus_rsp_valid_i (dbus_rsp_valid_o),
    .ibus_rsp_valid_i (ibus_rsp_valid_o),
    .rsp_data_i       (rsp_data_o),
    .sdram_i          (sdram_o),
    .csr_i            (csr_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] rom_word_at(input logic [ROM_ADDR_BITS-3:0] idx);
    return {{(34 - ROM_ADDR_BITS){1'b0}}, idx} ^ 32'hA5A5_0000;
  endfunction

  task automatic load_table();
    rows[0]  = '{BUS_I,  1'b0, 32'h0000_0040, 32'h0, 4'h0, MAX_SIZE_CODE, 32'h0};
    rows[1]  = '{BUS_D,  1'b1, 32'h0200_000C, 32'h1234_5678, 4'hF, CMD_SIZE_32, 32'h0};
    rows[2]  = '{BUS_D,  1'b1, 32'h0200_001C, 32'h0BAD_CAFE, 4'hF, CMD_SIZE_32, 32'h0};
    rows[3]  = '{BUS_D,  1'b0, 32'h0200_000C, 32'h0, 4'h0, CMD_SIZE_32, 32'h1234_5678};
    rows[4]  = '{BUS_D,  1'b0, 32'h0200_001C, 32'h0, 4'h0, CMD_SIZE_32, 32'h0BAD_CAFE};
    rows[5]  = '{BUS_D,  1'b1, 32'h0400_0100, 32'h1122_3344, 4'hF, CMD_SIZE_32, 32'h0};
    rows[6]  = '{BUS_D,  1'b0, 32'h0400_0100, 32'h0, 4'h0, CMD_SIZE_32, 32'h1122_3344};
    rows[7]  = '{BUS_D,  1'b1, 32'h0400_0110, 32'hCAFE_F00D, 4'hF, CMD_SIZE_32, 32'h0};
    // byte lane 2 then the low half of the same word
    rows[8]  = '{BUS_D,  1'b1, 32'h0400_0112, 32'h7777_7777, 4'h4, CMD_SIZE_8, 32'h0};
    rows[9]  = '{BUS_D,  1'b1, 32'h0400_0110, 32'hBEEF_BEEF, 4'h3, CMD_SIZE_16, 32'h0};
    rows[10] = '{BUS_D,  1'b0, 32'h0400_0110, 32'h0, 4'h0, CMD_SIZE_32, 32'hCA77_BEEF};
    rows[11] = '{BUS_DI, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 3'd3, 32'h0};
    rows[12] = '{BUS_D,  1'b0, 32'h0000_0200, 32'h0, 4'h0, 3'd4, 32'h0};
    rows[13] = '{BUS_D,  1'b0, 32'h0000_0004, 32'h0, 4'h0, CMD_SIZE_32, 32'h0};
  endtask

  task automatic push_burst(input logic is_ibus, input logic [31:0] addr, input int words);
    logic [ROM_ADDR_BITS-3:0] idx;
    idx = addr[ROM_ADDR_BITS-1:2];
    for (int k = 0; k < words; k++) begin
      mem_checker_inst.expect_word(k != 0, is_ibus, rom_word_at(idx));
      idx++;
    end
  endtask

  task automatic push_expected(input row_t row);
    int words;
    if (row.wr) return;
    if (row.addr[SEL_SDRAM_BIT] || row.addr[SEL_CSR_BIT]) begin
      mem_checker_inst.expect_word(1'b0, 1'b0, row.exp);
      return;
    end
    // size code s above a word carries 2^(s-2) words
    words = (row.size > CMD_SIZE_32) ? (1 << (row.size - CMD_SIZE_32)) : 1;
    if (row.bus != BUS_I) push_burst(1'b0, row.addr, words);
    if (row.bus != BUS_D) push_burst(1'b1, row.addr, words);
  endtask

  task automatic run_row(input row_t row);
    logic d_pend;
    logic i_pend;
    logic d_go;
    logic i_go;
    push_expected(row);
    @(posedge clk_i);
    #1;
    dbus_cmd_i = '{valid: row.bus != BUS_I, wr: row.wr, addr: row.addr, data: row.data,
                   mask: row.mask, size: row.size};
    ibus_cmd_i = '{valid: row.bus != BUS_D, addr: row.addr, size: row.size};
    d_pend = dbus_cmd_i.valid;
    i_pend = ibus_cmd_i.valid;
    while (d_pend || i_pend) begin
      @(negedge clk_i);
      d_go = d_pend && dbus_ready_o;
      i_go = i_pend && ibus_ready_o;
      @(posedge clk_i);
      #1;
      if (d_go) begin
        dbus_cmd_i.valid = 1'b0;
        d_pend = 1'b0;
      end
      if (i_go) begin
        ibus_cmd_i.valid = 1'b0;
        i_pend = 1'b0;
      end
    end
    // finished once idle and every expected word came back
    do begin
      @(posedge clk_i);
      #1;
    end while (!dbus_ready_o || mem_checker_inst.pending() != 0);
  endtask

  task automatic print_counts();
    $display("checks: %0d, errors: %0d", mem_checker_inst.check_count,
             mem_checker_inst.error_count);
  endtask

  // boot ROM answers one cycle after the address
  always @(posedge clk_i) begin
    #1;
    rom_data_i = rom_word_at(rom_addr_prev);
    rom_addr_prev = rom_addr_o;
  end

  // rdy comes 0 to 3 cycles after the earliest point the port looks at it
  always @(posedge clk_i) begin
    #1;
    sdram_rdy_i = 1'b0;
    if (sdram_o.rd || sdram_o.wr) begin
      if (sdram_age == 0) sdram_delay = int'($urandom % 4);
      if (sdram_age == sdram_delay + 2) begin
        sdram_rdy_i = 1'b1;
        if (sdram_o.wr) begin
          if (sdram_o.wmask[0]) sdram_mem[sdram_o.addr[7:0]][7:0] = sdram_o.wdata[7:0];
          if (sdram_o.wmask[1]) sdram_mem[sdram_o.addr[7:0]][15:8] = sdram_o.wdata[15:8];
        end else begin
          sdram_rdata_i = sdram_mem[sdram_o.addr[7:0]];
        end
      end
      sdram_age++;
    end else begin
      sdram_age = 0;
    end
  end

  // CSR slave stalls a random 0 to 2 cycles, acks the cycle after taking a request
  always @(posedge clk_i) begin
    #1;
    csr_ack_i = 1'b0;
    if (csr_taken) begin
      csr_ack_i = 1'b1;
      if (csr_we_hold) csr_regs[csr_adr_hold] = csr_dat_hold;
      csr_dat_i = csr_regs[csr_adr_hold];
      csr_taken = 1'b0;
    end
    csr_stall_i = 1'b0;
    if (csr_o.cyc && csr_o.stb) begin
      if (!csr_stb_seen) begin
        csr_stall_left = int'($urandom % 3);
        csr_stb_seen = 1'b1;
      end
      if (csr_stall_left != 0) begin
        csr_stall_i = 1'b1;
        csr_stall_left--;
      end else begin
        csr_taken = 1'b1;
        csr_we_hold = csr_o.we;
        csr_adr_hold = csr_o.adr;
        csr_dat_hold = csr_o.dat;
      end
    end else begin
      csr_stb_seen = 1'b0;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the DUT stopped making progress", TIMEOUT_CYCLES);
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed_val = $urandom(32'h910c);
    clk_i = 1'b0;
    rst_i = 1'b1;
    dbus_cmd_i = '0;
    ibus_cmd_i = '0;
    sdram_rdy_i = 1'b0;
    sdram_rdata_i = 16'h0;
    csr_stall_i = 1'b0;
    csr_ack_i = 1'b0;
    csr_dat_i = 32'h0;
    rom_data_i = 32'h0;
    rom_addr_prev = '0;
    sdram_age = 0;
    sdram_delay = 0;
    csr_stall_left = 0;
    csr_stb_seen = 1'b0;
    csr_taken = 1'b0;
    csr_we_hold = 1'b0;
    csr_adr_hold = 4'h0;
    csr_dat_hold = 32'h0;
    for (int i = 0; i < 256; i++) sdram_mem[i] = {8'(i), ~8'(i)};
    for (int i = 0; i < 16; i++) csr_regs[i] = 32'hC500_0000 | i;
    load_table();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    mem_checker_inst.check_reset_state();
    for (int r = 0; r < NUM_ROWS; r++) run_row(rows[r]);
    repeat (3) @(posedge clk_i);
    print_counts();
    if (mem_checker_inst.error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
source/memctl_pkg.sv
source/rsp_path.sv
source/rom_reader.sv
source/csr_port.sv
source/sdram_port.sv
source/dispatch_fsm.sv
source/mem_ctrl.sv
verification/mem_checker.sv
verification/tb_mem_ctrl.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_mem_ctrl -o sim_mem_ctrl

run: build
	./obj_dir/sim_mem_ctrl 2>&1 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module tb_mem_ctrl

clean:
	rm -rf obj_dir sim.log
